// File: px_skip_pkg.sv
`default_nettype none

package px_skip_pkg;

  // width of every skip setting and run counter.
  localparam int CNT_W = 16;

  typedef enum logic [2:0] {
    PASS_S        = 3'd0, // pixels go through.
    SKIP_PX_S     = 3'd1, // dropping a pixel run.
    SKIP_ADD_PX_S = 3'd2, // one extra dropped pixel.
    SKIP_LN_S     = 3'd3, // dropping whole lines.
    SKIP_ADD_LN_S = 3'd4  // one extra dropped line.
  } skip_state_e;

endpackage

`default_nettype wire

// File: skip_cfg_latch.sv
`timescale 1ns/1ps
`default_nettype none

module skip_cfg_latch (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_skip_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_to_skip_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  add_px_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_skip_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_to_skip_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  add_ln_interval_i,
  input  wire logic                           frame_start_i,
  output logic      [px_skip_pkg::CNT_W-1:0]  px_pass_len_o,
  output logic      [px_skip_pkg::CNT_W-1:0]  px_skip_len_o,
  output logic      [px_skip_pkg::CNT_W-1:0]  px_add_len_o,
  output logic      [px_skip_pkg::CNT_W-1:0]  ln_pass_len_o,
  output logic      [px_skip_pkg::CNT_W-1:0]  ln_skip_len_o,
  output logic      [px_skip_pkg::CNT_W-1:0]  ln_add_len_o,
  output logic                                px_skip_en_o,
  output logic                                ln_skip_en_o
);

// lengths are stored minus one so the decider compares counters directly.
always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      px_pass_len_o <= '0;
      px_skip_len_o <= '0;
      px_add_len_o  <= '0;
      ln_pass_len_o <= '0;
      ln_skip_len_o <= '0;
      ln_add_len_o  <= '0;
      px_skip_en_o  <= 1'b0; // pass everything until first frame.
      ln_skip_en_o  <= 1'b0;
    end
  else
    if (frame_start_i)
      begin
        px_pass_len_o <= px_skip_interval_i - px_to_skip_i - 1'b1;
        px_skip_len_o <= px_to_skip_i - 1'b1;
        px_add_len_o  <= add_px_interval_i;
        ln_pass_len_o <= ln_skip_interval_i - ln_to_skip_i - 1'b1;
        ln_skip_len_o <= ln_to_skip_i - 1'b1;
        ln_add_len_o  <= add_ln_interval_i;
        px_skip_en_o  <= px_to_skip_i != '0;
        ln_skip_en_o  <= ln_to_skip_i != '0;
      end

endmodule

`default_nettype wire

// File: stream_reg_stage.sv
`timescale 1ns/1ps
`default_nettype none

module stream_reg_stage #(
  parameter int PX_WIDTH = 30
)(
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic [PX_WIDTH-1:0] s_tdata_i,
  input  wire logic                s_tvalid_i,
  input  wire logic                s_tlast_i,
  input  wire logic                s_tuser_i,
  output logic                     s_tready_o,
  output logic      [PX_WIDTH-1:0] m_tdata_o,
  output logic                     m_tvalid_o,
  output logic                     m_tlast_o,
  output logic                     m_tuser_o,
  input  wire logic                m_tready_i
);

logic full;
logic load;

// take a new beat when empty or while the held one leaves.
assign s_tready_o = !full || m_tready_i;
assign load       = s_tvalid_i && s_tready_o;
assign m_tvalid_o = full;

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    full <= 1'b0;
  else
    if (load)
      full <= 1'b1;
    else
      if (m_tready_i)
        full <= 1'b0;

always_ff @(posedge clk_i)
  if (load)
    begin
      m_tdata_o <= s_tdata_i;
      m_tlast_o <= s_tlast_i;
      m_tuser_o <= s_tuser_i;
    end

endmodule

`default_nettype wire

// File: skip_decider.sv
`timescale 1ns/1ps
`default_nettype none

module skip_decider #(
  parameter int PX_WIDTH = 30
)(
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic [PX_WIDTH-1:0]            s_tdata_i,
  input  wire logic                           s_tvalid_i,
  input  wire logic                           s_tlast_i,
  input  wire logic                           s_tuser_i,
  output logic                                s_tready_o,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_pass_len_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_skip_len_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_add_len_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_pass_len_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_skip_len_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_add_len_i,
  input  wire logic                           px_skip_en_i,
  input  wire logic                           ln_skip_en_i,
  output logic      [PX_WIDTH-1:0]            m_tdata_o,
  output logic                                m_tvalid_o,
  output logic                                m_tlast_o,
  output logic                                m_tuser_o,
  input  wire logic                           m_tready_i
);

localparam int CNT_W = px_skip_pkg::CNT_W;

px_skip_pkg::skip_state_e state, st, nxt_state;

logic             first_beat;
logic             line_start;
logic             frame_start;
logic             kept_line;
logic             keep;
logic             xfer;
logic [CNT_W-1:0] px_pass_cnt, px_skip_cnt, px_add_cnt;
logic [CNT_W-1:0] ln_pass_cnt, ln_skip_cnt, ln_add_cnt;
logic [CNT_W-1:0] px_pass_cur, px_skip_cur, px_add_cur;
logic [CNT_W-1:0] ln_pass_cur, ln_skip_cur, ln_add_cur;
logic [CNT_W-1:0] px_pass_nxt, px_skip_nxt, px_add_nxt;
logic [CNT_W-1:0] ln_pass_nxt, ln_skip_nxt, ln_add_nxt;
logic [CNT_W-1:0] px_add_inc, ln_add_inc;

assign frame_start = s_tvalid_i && s_tuser_i;
assign line_start  = first_beat || frame_start;

// a new frame always opens in pass with cleared line counters.
assign st          = frame_start ? px_skip_pkg::PASS_S : state;
assign px_pass_cur = line_start  ? '0 : px_pass_cnt;
assign px_skip_cur = line_start  ? '0 : px_skip_cnt;
assign px_add_cur  = line_start  ? '0 : px_add_cnt;
assign ln_pass_cur = frame_start ? '0 : ln_pass_cnt;
assign ln_skip_cur = frame_start ? '0 : ln_skip_cnt;
assign ln_add_cur  = frame_start ? '0 : ln_add_cnt;
assign px_add_inc  = px_add_cur + 1'b1;
assign ln_add_inc  = ln_add_cur + 1'b1;

assign kept_line = st == px_skip_pkg::PASS_S || st == px_skip_pkg::SKIP_PX_S ||
                   st == px_skip_pkg::SKIP_ADD_PX_S;
assign keep      = st == px_skip_pkg::PASS_S || ( kept_line && s_tlast_i ); // last px kept.

assign m_tvalid_o = s_tvalid_i && keep;
assign m_tdata_o  = s_tdata_i;
assign m_tlast_o  = s_tlast_i;
assign m_tuser_o  = s_tuser_i;
assign s_tready_o = keep ? m_tready_i : 1'b1; // drops are taken at once.
assign xfer       = s_tvalid_i && s_tready_o;

always_comb
  begin
    nxt_state   = st;
    px_pass_nxt = px_pass_cur;
    px_skip_nxt = px_skip_cur;
    px_add_nxt  = px_add_cur;
    ln_pass_nxt = ln_pass_cur;
    ln_skip_nxt = ln_skip_cur;
    ln_add_nxt  = ln_add_cur;
    case (st)
      px_skip_pkg::PASS_S:
        if (!s_tlast_i)
          if (px_skip_en_i && px_pass_cur == px_pass_len_i)
            begin
              nxt_state   = px_skip_pkg::SKIP_PX_S;
              px_pass_nxt = '0;
              px_skip_nxt = '0;
            end
          else
            px_pass_nxt = px_pass_cur + 1'b1;
      px_skip_pkg::SKIP_PX_S:
        if (!s_tlast_i)
          if (px_skip_cur == px_skip_len_i)
            begin
              px_skip_nxt = '0;
              if (px_add_len_i != '0 && px_add_inc == px_add_len_i)
                begin
                  nxt_state  = px_skip_pkg::SKIP_ADD_PX_S;
                  px_add_nxt = '0;
                end
              else
                begin
                  nxt_state  = px_skip_pkg::PASS_S;
                  px_add_nxt = px_add_inc;
                end
            end
          else
            px_skip_nxt = px_skip_cur + 1'b1;
      px_skip_pkg::SKIP_ADD_PX_S:
        if (!s_tlast_i)
          nxt_state = px_skip_pkg::PASS_S;
      px_skip_pkg::SKIP_LN_S:
        if (s_tlast_i)
          if (ln_skip_cur == ln_skip_len_i)
            begin
              ln_skip_nxt = '0;
              if (ln_add_len_i != '0 && ln_add_inc == ln_add_len_i)
                begin
                  nxt_state  = px_skip_pkg::SKIP_ADD_LN_S;
                  ln_add_nxt = '0;
                end
              else
                begin
                  nxt_state  = px_skip_pkg::PASS_S;
                  ln_add_nxt = ln_add_inc;
                end
            end
          else
            ln_skip_nxt = ln_skip_cur + 1'b1;
      px_skip_pkg::SKIP_ADD_LN_S:
        if (s_tlast_i)
          nxt_state = px_skip_pkg::PASS_S;
      default:
        nxt_state = px_skip_pkg::PASS_S;
    endcase
    // end of a kept line decides what the next line does.
    if (kept_line && s_tlast_i)
      if (ln_skip_en_i && ln_pass_cur == ln_pass_len_i)
        begin
          nxt_state   = px_skip_pkg::SKIP_LN_S;
          ln_pass_nxt = '0;
          ln_skip_nxt = '0;
        end
      else
        begin
          nxt_state   = px_skip_pkg::PASS_S;
          ln_pass_nxt = ln_pass_cur + 1'b1;
        end
  end

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      state       <= px_skip_pkg::PASS_S;
      first_beat  <= 1'b1;
      px_pass_cnt <= '0;
      px_skip_cnt <= '0;
      px_add_cnt  <= '0;
      ln_pass_cnt <= '0;
      ln_skip_cnt <= '0;
      ln_add_cnt  <= '0;
    end
  else
    if (xfer)
      begin
        state       <= nxt_state;
        first_beat  <= s_tlast_i;
        px_pass_cnt <= px_pass_nxt;
        px_skip_cnt <= px_skip_nxt;
        px_add_cnt  <= px_add_nxt;
        ln_pass_cnt <= ln_pass_nxt;
        ln_skip_cnt <= ln_skip_nxt;
        ln_add_cnt  <= ln_add_nxt;
      end

endmodule

`default_nettype wire

// File: line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter int PX_WIDTH    = 30,
  parameter int FRAME_RES_X = 1920
)(
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic [PX_WIDTH-1:0] s_tdata_i,
  input  wire logic                s_tvalid_i,
  input  wire logic                s_tlast_i,
  input  wire logic                s_tuser_i,
  output logic                     s_tready_o,
  output logic      [PX_WIDTH-1:0] m_tdata_o,
  output logic                     m_tvalid_o,
  output logic                     m_tlast_o,
  output logic                     m_tuser_o,
  input  wire logic                m_tready_i
);

localparam int              ADDR_W    = FRAME_RES_X > 1 ? $clog2(FRAME_RES_X) : 1;
localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_RES_X - 1);
localparam logic [ADDR_W:0]   DEPTH     = (ADDR_W + 1)'(FRAME_RES_X);

logic [PX_WIDTH+1:0] mem [FRAME_RES_X]; // {tuser, tlast, tdata}.
logic [ADDR_W-1:0]   wr_ptr;
logic [ADDR_W-1:0]   rd_ptr;
logic [ADDR_W:0]     used;
logic [ADDR_W:0]     line_cnt;
logic                wr;
logic                rd;
logic                line_in;
logic                line_out;

assign s_tready_o = used != DEPTH;
assign wr         = s_tvalid_i && s_tready_o;

// only whole lines are shown downstream.
assign m_tvalid_o = line_cnt != '0;
assign rd         = m_tvalid_o && m_tready_i;
assign m_tdata_o  = mem[rd_ptr][PX_WIDTH-1:0];
assign m_tlast_o  = mem[rd_ptr][PX_WIDTH];
assign m_tuser_o  = mem[rd_ptr][PX_WIDTH+1];

assign line_in  = wr && s_tlast_i;
assign line_out = rd && m_tlast_o;

always_ff @(posedge clk_i)
  if (wr)
    mem[wr_ptr] <= {s_tuser_i, s_tlast_i, s_tdata_i};

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
  else
    begin
      if (wr)
        wr_ptr <= wr_ptr == LAST_ADDR ? '0 : wr_ptr + 1'b1; // depth need not be 2^n.
      if (rd)
        rd_ptr <= rd_ptr == LAST_ADDR ? '0 : rd_ptr + 1'b1;
    end

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    used <= '0;
  else
    if (wr && !rd)
      used <= used + 1'b1;
    else
      if (rd && !wr)
        used <= used - 1'b1;

always_ff @(posedge clk_i, posedge rst_i)
  if (rst_i)
    line_cnt <= '0;
  else
    if (line_in && !line_out)
      line_cnt <= line_cnt + 1'b1;
    else
      if (line_out && !line_in)
        line_cnt <= line_cnt - 1'b1;

endmodule

`default_nettype wire

// File: px_skipper_top.sv
`timescale 1ns/1ps
`default_nettype none

module px_skipper_top #(
  parameter int PX_WIDTH    = 30,
  parameter int FRAME_RES_X = 1920
)(
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_skip_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  px_to_skip_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  add_px_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_skip_interval_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  ln_to_skip_i,
  input  wire logic [px_skip_pkg::CNT_W-1:0]  add_ln_interval_i,
  input  wire logic [PX_WIDTH-1:0]            video_tdata_i,
  input  wire logic                           video_tvalid_i,
  input  wire logic                           video_tlast_i,
  input  wire logic                           video_tuser_i,
  output logic                                video_tready_o,
  output logic      [PX_WIDTH-1:0]            video_tdata_o,
  output logic                                video_tvalid_o,
  output logic                                video_tlast_o,
  output logic                                video_tuser_o,
  input  wire logic                           video_tready_i
);

logic [PX_WIDTH-1:0]            reg_tdata, dec_tdata;
logic                           reg_tvalid, reg_tlast, reg_tuser, reg_tready;
logic                           dec_tvalid, dec_tlast, dec_tuser, dec_tready;
logic                           frame_start;
logic [px_skip_pkg::CNT_W-1:0]  px_pass_len, px_skip_len, px_add_len;
logic [px_skip_pkg::CNT_W-1:0]  ln_pass_len, ln_skip_len, ln_add_len;
logic                           px_skip_en, ln_skip_en;

// settings for a frame are taken as its tuser beat enters.
assign frame_start = video_tvalid_i && video_tready_o && video_tuser_i;

stream_reg_stage #(
  .PX_WIDTH   ( PX_WIDTH       )
) stream_reg_stage_inst (
  .clk_i      ( clk_i          ),
  .rst_i      ( rst_i          ),
  .s_tdata_i  ( video_tdata_i  ),
  .s_tvalid_i ( video_tvalid_i ),
  .s_tlast_i  ( video_tlast_i  ),
  .s_tuser_i  ( video_tuser_i  ),
  .s_tready_o ( video_tready_o ),
  .m_tdata_o  ( reg_tdata      ),
  .m_tvalid_o ( reg_tvalid     ),
  .m_tlast_o  ( reg_tlast      ),
  .m_tuser_o  ( reg_tuser      ),
  .m_tready_i ( reg_tready     )
);

skip_cfg_latch skip_cfg_latch_inst (
  .clk_i              ( clk_i              ),
  .rst_i              ( rst_i              ),
  .px_skip_interval_i ( px_skip_interval_i ),
  .px_to_skip_i       ( px_to_skip_i       ),
  .add_px_interval_i  ( add_px_interval_i  ),
  .ln_skip_interval_i ( ln_skip_interval_i ),
  .ln_to_skip_i       ( ln_to_skip_i       ),
  .add_ln_interval_i  ( add_ln_interval_i  ),
  .frame_start_i      ( frame_start        ),
  .px_pass_len_o      ( px_pass_len        ),
  .px_skip_len_o      ( px_skip_len        ),
  .px_add_len_o       ( px_add_len         ),
  .ln_pass_len_o      ( ln_pass_len        ),
  .ln_skip_len_o      ( ln_skip_len        ),
  .ln_add_len_o       ( ln_add_len         ),
  .px_skip_en_o       ( px_skip_en         ),
  .ln_skip_en_o       ( ln_skip_en         )
);

skip_decider #(
  .PX_WIDTH      ( PX_WIDTH    )
) skip_decider_inst (
  .clk_i         ( clk_i       ),
  .rst_i         ( rst_i       ),
  .s_tdata_i     ( reg_tdata   ),
  .s_tvalid_i    ( reg_tvalid  ),
  .s_tlast_i     ( reg_tlast   ),
  .s_tuser_i     ( reg_tuser   ),
  .s_tready_o    ( reg_tready  ),
  .px_pass_len_i ( px_pass_len ),
  .px_skip_len_i ( px_skip_len ),
  .px_add_len_i  ( px_add_len  ),
  .ln_pass_len_i ( ln_pass_len ),
  .ln_skip_len_i ( ln_skip_len ),
  .ln_add_len_i  ( ln_add_len  ),
  .px_skip_en_i  ( px_skip_en  ),
  .ln_skip_en_i  ( ln_skip_en  ),
  .m_tdata_o     ( dec_tdata   ),
  .m_tvalid_o    ( dec_tvalid  ),
  .m_tlast_o     ( dec_tlast   ),
  .m_tuser_o     ( dec_tuser   ),
  .m_tready_i    ( dec_tready  )
);

line_fifo #(
  .PX_WIDTH    ( PX_WIDTH       ),
  .FRAME_RES_X ( FRAME_RES_X    )
) line_fifo_inst (
  .clk_i       ( clk_i          ),
  .rst_i       ( rst_i          ),
  .s_tdata_i   ( dec_tdata      ),
  .s_tvalid_i  ( dec_tvalid     ),
  .s_tlast_i   ( dec_tlast      ),
  .s_tuser_i   ( dec_tuser      ),
  .s_tready_o  ( dec_tready     ),
  .m_tdata_o   ( video_tdata_o  ),
  .m_tvalid_o  ( video_tvalid_o ),
  .m_tlast_o   ( video_tlast_o  ),
  .m_tuser_o   ( video_tuser_o  ),
  .m_tready_i  ( video_tready_i )
);

endmodule

`default_nettype wire

// File: px_skipper_tb.sv
`timescale 1ns/1ps
`default_nettype none

module px_skipper_tb;

localparam int          PX_W    = 16;
localparam int          RES_X   = 16;
localparam int          CNT_W   = px_skip_pkg::CNT_W;
localparam int          N_ROWS  = 6;
localparam int          TIMEOUT = 200;
localparam logic [31:0] SEED    = 32'hedd5f857;

// px_int, px_skip, add_px, ln_int, ln_skip, add_ln, lines, len, mid change, kept lines.
int cases [N_ROWS][10] = '{
  '{0, 0, 0, 0, 0, 0, 3,  8, 0, 3},
  '{4, 2, 0, 0, 0, 0, 3, 11, 0, 3},
  '{3, 1, 2, 3, 1, 2, 8, 10, 0, 5},
  '{6, 2, 0, 3, 2, 0, 7,  6, 0, 3},
  '{5, 2, 3, 4, 1, 0, 6, 12, 1, 5},
  '{2, 1, 1, 2, 1, 1, 6,  9, 0, 2}
};

logic                 clk_i = 1'b0;
logic                 rst_i;
logic [CNT_W-1:0]     px_skip_interval, px_to_skip, add_px_interval;
logic [CNT_W-1:0]     ln_skip_interval, ln_to_skip, add_ln_interval;
logic [PX_W-1:0]      video_tdata_i;
logic                 video_tvalid_i, video_tlast_i, video_tuser_i, video_tready_o;
logic [PX_W-1:0]      video_tdata_o;
logic                 video_tvalid_o, video_tlast_o, video_tuser_o, video_tready_i;
logic [PX_W+1:0]      exp_q [$]; // {tuser, tlast, tdata}.
logic [PX_W+1:0]      exp_beat;
logic [31:0]          in_seed  = SEED;
logic [31:0]          rdy_seed = SEED ^ 32'h5a5a5a5a;
logic                 in_line  = 1'b0;
int                   lines_seen = 0;
px_skip_pkg::skip_state_e dec_state;

px_skipper_top #(
  .PX_WIDTH           ( PX_W             ),
  .FRAME_RES_X        ( RES_X            )
) px_skipper_top_inst (
  .clk_i              ( clk_i            ),
  .rst_i              ( rst_i            ),
  .px_skip_interval_i ( px_skip_interval ),
  .px_to_skip_i       ( px_to_skip       ),
  .add_px_interval_i  ( add_px_interval  ),
  .ln_skip_interval_i ( ln_skip_interval ),
  .ln_to_skip_i       ( ln_to_skip       ),
  .add_ln_interval_i  ( add_ln_interval  ),
  .video_tdata_i      ( video_tdata_i    ),
  .video_tvalid_i     ( video_tvalid_i   ),
  .video_tlast_i      ( video_tlast_i    ),
  .video_tuser_i      ( video_tuser_i    ),
  .video_tready_o     ( video_tready_o   ),
  .video_tdata_o      ( video_tdata_o    ),
  .video_tvalid_o     ( video_tvalid_o   ),
  .video_tlast_o      ( video_tlast_o    ),
  .video_tuser_o      ( video_tuser_o    ),
  .video_tready_i     ( video_tready_i   )
);

always #2 clk_i = ~clk_i;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// pass run, skip run, repeat; every add-th skip run is one longer.
function automatic bit run_kept(input int idx, input int interval, input int to_skip,
                                input int add);
  int pos;
  int period;
  pos = 0;
  if (to_skip == 0)
    return 1'b1;
  for (period = 1; period <= idx + 1; period++)
    begin
      pos += interval - to_skip;
      if (idx < pos)
        return 1'b1;
      pos += to_skip + ((add != 0 && period % add == 0) ? 1 : 0);
      if (idx < pos)
        return 1'b0;
    end
  return 1'b1;
endfunction

function automatic logic [PX_W-1:0] pixel_word(input int r, input int l, input int j);
  return PX_W'((r << 12) | (l << 8) | j); // frame, line, pixel.
endfunction

function automatic void queue_frame(input int r);
  int l;
  int j;
  for (l = 0; l < cases[r][6]; l++)
    if (run_kept(l, cases[r][3], cases[r][4], cases[r][5]))
      for (j = 0; j < cases[r][7]; j++)
        if (j == cases[r][7] - 1 || run_kept(j, cases[r][0], cases[r][1], cases[r][2]))
          exp_q.push_back({l == 0 && j == 0, j == cases[r][7] - 1, pixel_word(r, l, j)});
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
endtask

task automatic abort_run(input string why);
  $display("%s at %0t", why, $time);
  $display("CHECKS FAILED");
  $fatal(1);
endtask

task automatic set_settings(input int pi, input int ps, input int pa, input int li,
                            input int ls, input int la);
  px_skip_interval = CNT_W'(pi);
  px_to_skip       = CNT_W'(ps);
  add_px_interval  = CNT_W'(pa);
  ln_skip_interval = CNT_W'(li);
  ln_to_skip       = CNT_W'(ls);
  add_ln_interval  = CNT_W'(la);
endtask

task automatic send_beat(input logic [PX_W-1:0] data, input logic last, input logic user);
  int  waited;
  bit  accepted;
  waited   = 0;
  accepted = 1'b0;
  in_seed  = lcg_next(in_seed);
  if (in_seed[31:29] == 3'd0) // idle cycle on the input.
    begin
      video_tvalid_i = 1'b0;
      @(posedge clk_i);
      #1;
    end
  video_tdata_i  = data;
  video_tlast_i  = last;
  video_tuser_i  = user;
  video_tvalid_i = 1'b1;
  while (!accepted)
    begin
      @(negedge clk_i);
      accepted = video_tready_o;
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT)
        abort_run("input beat was never accepted");
    end
  video_tvalid_i = 1'b0;
endtask

task automatic send_frame(input int r);
  int l;
  int j;
  set_settings(cases[r][0], cases[r][1], cases[r][2], cases[r][3], cases[r][4],
               cases[r][5]);
  queue_frame(r);
  for (l = 0; l < cases[r][6]; l++)
    begin
      if (cases[r][8] != 0 && l == cases[r][6] / 2)
        set_settings(3, 2, 1, 3, 2, 1); // must wait for the next frame.
      for (j = 0; j < cases[r][7]; j++)
        send_beat(pixel_word(r, l, j), j == cases[r][7] - 1, l == 0 && j == 0);
    end
endtask

always @(posedge clk_i)
  begin
    #1;
    rdy_seed       = lcg_next(rdy_seed);
    video_tready_i = rdy_seed[31:30] == 2'b11; // sparse ready so the FIFO fills.
  end

// negedge sample sees what the next rising edge transfers.
always @(negedge clk_i)
  if (!rst_i)
    begin
      if (in_line)
        check_value("video_tvalid_o", video_tvalid_o, 1'b1);
      if (video_tvalid_o && video_tready_i)
        if (exp_q.size() == 0)
          begin
            dec_state = px_skipper_top_inst.skip_decider_inst.state;
            abort_run($sformatf("unexpected output beat %h with decider in %s",
                                video_tdata_o, dec_state.name()));
          end
        else
          begin
            exp_beat = exp_q.pop_front();
            check_value("video_tdata_o", video_tdata_o, exp_beat[PX_W-1:0]);
            check_value("video_tlast_o", video_tlast_o, exp_beat[PX_W]);
            check_value("video_tuser_o", video_tuser_o, exp_beat[PX_W+1]);
            in_line = !video_tlast_o;
            if (video_tlast_o)
              lines_seen++;
          end
    end

initial
  begin
    int r;
    int waited;
    int total;
    total = 0;
    rst_i = 1'b1;
    set_settings(0, 0, 0, 0, 0, 0);
    video_tdata_i  = '0;
    video_tvalid_i = 1'b0;
    video_tlast_i  = 1'b0;
    video_tuser_i  = 1'b0;
    video_tready_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("video_tvalid_o", video_tvalid_o, 1'b0);
    check_value("video_tready_o", video_tready_o, 1'b1);
    @(posedge clk_i);
    #1;
    for (r = 0; r < N_ROWS; r++)
      begin
        send_frame(r);
        total += cases[r][9];
      end
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT * 4)
      begin
        @(posedge clk_i);
        waited++;
      end
    repeat (20) @(posedge clk_i); // nothing more may come out.
    if (exp_q.size() == 0)
      begin
        check_value("output line count", lines_seen, total);
        $display("ALL CHECKS PASSED");
        $finish;
      end
    else
      abort_run("output did not drain");
  end

endmodule

`default_nettype wire

// File: px_skipper_top.f
px_skip_pkg.sv
skip_cfg_latch.sv
stream_reg_stage.sv
skip_decider.sv
line_fifo.sv
px_skipper_top.sv
px_skipper_tb.sv
